// File: source/x86_decode_pkg.sv
`default_nettype none

package x86_decode_pkg;

    // general register index, eax through edi
    typedef logic [2:0] reg_idx_t;

    // operand type code as it arrives from the decoder
    typedef logic [2:0] op_type_t;

    localparam op_type_t OP_NONE      = 3'd0;
    localparam op_type_t OP_REGISTER  = 3'd1;
    localparam op_type_t OP_SEGMENT   = 3'd2;
    localparam op_type_t OP_MM        = 3'd3;
    localparam op_type_t OP_MODRM     = 3'd4;
    localparam op_type_t OP_IMMEDIATE = 3'd5;
    localparam op_type_t OP_MEMORY    = 3'd6;

    // operand size, only byte matters here
    typedef logic [1:0] reg_size_t;

    localparam reg_size_t SIZE_BYTE = 2'd0;

    // mod field: r/m names a register
    localparam logic [1:0] MOD_REGISTER = 2'b11;
    // mod field: memory form without displacement
    localparam logic [1:0] MOD_MEM_NO_DISP = 2'b00;

    // r/m escape to a sib byte
    localparam reg_idx_t RM_SIB = 3'b100;
    // with mod 00 this is a bare disp32, no register involved
    localparam reg_idx_t RM_DISP32 = 3'b101;
    // sib index value meaning no index register
    localparam reg_idx_t SIB_NO_INDEX = 3'b100;

    // byte registers ah..bh live in the upper half of eax..ebx
    function automatic reg_idx_t sized_reg_index(input reg_idx_t idx, input reg_size_t size);
        reg_idx_t result;
        result = idx;
        if (size == SIZE_BYTE && idx[2]) begin
            result = {1'b0, idx[1:0]};
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// File: source/scoreboard_pkg.sv
`default_nettype none

package scoreboard_pkg;

    // one busy counter per general register
    localparam int NUM_REGS = 8;

    // esp, checked by stack operations
    localparam int STACK_REG = 4;

    // two source slots per operand, two operands
    localparam int NUM_SOURCES = 4;

    // counter width the top level uses unless told otherwise
    // 4 bits holds up to 15 writes in flight per register
    localparam int DEFAULT_COUNT_WIDTH = 4;

    // one bit per register
    typedef logic [NUM_REGS-1:0] reg_mask_t;

endpackage

`default_nettype wire

// File: source/operand_source_decode.sv
`default_nettype none

// finds the registers one operand reads
// slot 0 is the register itself, the r/m register or the sib base
// slot 1 is only ever the sib index
module operand_source_decode (
    input  wire x86_decode_pkg::op_type_t  op_type,
    input  wire x86_decode_pkg::reg_idx_t  op_reg,
    input  wire logic [7:0]                mod_rm,
    input  wire logic [7:0]                sib,
    input  wire x86_decode_pkg::reg_size_t register_size,
    output x86_decode_pkg::reg_idx_t       src0_reg,
    output logic                           src0_valid,
    output x86_decode_pkg::reg_idx_t       src1_reg,
    output logic                           src1_valid
);

    // mod r/m and sib fields
    logic [1:0]               mod;
    x86_decode_pkg::reg_idx_t rm;
    x86_decode_pkg::reg_idx_t sib_base;
    x86_decode_pkg::reg_idx_t sib_index;

    // operand type classes
    logic is_direct;
    logic is_modrm;

    // mod r/m addressing forms
    logic mod_is_reg;
    logic rm_is_disp32;
    logic rm_is_sib;

    assign mod       = mod_rm[7:6];
    assign rm        = mod_rm[2:0];
    assign sib_base  = sib[2:0];
    assign sib_index = sib[5:3];

    // register and memory operands both carry the register in op_reg
    assign is_direct = (op_type == x86_decode_pkg::OP_REGISTER) ||
                       (op_type == x86_decode_pkg::OP_MEMORY);
    assign is_modrm  = (op_type == x86_decode_pkg::OP_MODRM);

    assign mod_is_reg   = (mod == x86_decode_pkg::MOD_REGISTER);
    assign rm_is_disp32 = (mod == x86_decode_pkg::MOD_MEM_NO_DISP) &&
                          (rm == x86_decode_pkg::RM_DISP32);
    assign rm_is_sib    = (rm == x86_decode_pkg::RM_SIB);

    // slot 0 valid
    // every mod r/m form reads a register except the bare disp32
    assign src0_valid = is_direct || (is_modrm && !rm_is_disp32);

    // slot 0 register
    always_comb begin
        if (is_direct) begin
            src0_reg = x86_decode_pkg::sized_reg_index(op_reg, register_size);
        end else if (mod_is_reg) begin
            // register form, r/m may name a byte register
            src0_reg = x86_decode_pkg::sized_reg_index(rm, register_size);
        end else if (!rm_is_sib) begin
            // memory form, r/m is the full width base
            src0_reg = rm;
        end else begin
            // address comes through the sib byte
            src0_reg = sib_base;
        end
    end

    // slot 1 only exists for a memory form with a real sib index
    assign src1_valid = is_modrm && !mod_is_reg && rm_is_sib &&
                        (sib_index != x86_decode_pkg::SIB_NO_INDEX);

    // index register is always full width
    assign src1_reg = sib_index;

endmodule

`default_nettype wire

// File: source/scoreboard_update.sv
`default_nettype none

// handshake and per-register update masks
// inc_mask marks the destination of an accepted instruction
// dec_mask marks the register coming back from writeback
module scoreboard_update (
    input  wire logic                      in_valid,
    input  wire logic                      next_stage_ready,
    input  wire logic                      stall,
    input  wire x86_decode_pkg::op_type_t  op0_type,
    input  wire x86_decode_pkg::reg_idx_t  op0_reg,
    input  wire logic [7:0]                mod_rm,
    input  wire x86_decode_pkg::reg_size_t register_size,
    input  wire logic                      wb_valid,
    input  wire x86_decode_pkg::reg_idx_t  wb_reg,
    input  wire x86_decode_pkg::reg_size_t wb_size,
    output logic                           in_ready,
    output scoreboard_pkg::reg_mask_t      inc_mask,
    output scoreboard_pkg::reg_mask_t      dec_mask
);

    logic                     accept;
    logic                     dest_valid;
    x86_decode_pkg::reg_idx_t dest_reg;
    x86_decode_pkg::reg_idx_t wb_reg_sized;

    // stage takes new work only when downstream can and no hazard is pending
    assign in_ready = next_stage_ready && !stall;
    assign accept   = in_valid && in_ready;

    // op0 destination
    // a plain register, or mod r/m in its register form
    always_comb begin
        dest_valid = 1'b0;
        dest_reg   = x86_decode_pkg::sized_reg_index(op0_reg, register_size);
        if (op0_type == x86_decode_pkg::OP_REGISTER) begin
            dest_valid = 1'b1;
        end else if (op0_type == x86_decode_pkg::OP_MODRM &&
                     mod_rm[7:6] == x86_decode_pkg::MOD_REGISTER) begin
            dest_valid = 1'b1;
            dest_reg   = x86_decode_pkg::sized_reg_index(mod_rm[2:0], register_size);
        end
    end

    // byte writeback to ah..bh retires the full register
    assign wb_reg_sized = x86_decode_pkg::sized_reg_index(wb_reg, wb_size);

    // one-hot increment, only for an instruction that actually moves on
    always_comb begin
        inc_mask = '0;
        if (accept && dest_valid) begin
            inc_mask[dest_reg] = 1'b1;
        end
    end

    // writeback is never held back, so no handshake term here
    always_comb begin
        dec_mask = '0;
        if (wb_valid) begin
            dec_mask[wb_reg_sized] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/reg_busy_counter.sv
`default_nettype none

// outstanding write count for one register
// busy while any write to it is still in flight
module reg_busy_counter #(
    parameter int COUNT_WIDTH = scoreboard_pkg::DEFAULT_COUNT_WIDTH
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic inc,
    input  wire logic dec,
    output logic      busy
);

    localparam logic [COUNT_WIDTH-1:0] ONE = 1;

    logic [COUNT_WIDTH-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({inc, dec})
                // new write issued
                2'b10: count <= count + ONE;
                // write retired
                2'b01: count <= count - ONE;
                // issue and retire together cancel out
                default: count <= count;
            endcase
        end
    end

    assign busy = (count != '0);

endmodule

`default_nettype wire

// File: source/hazard_check.sv
`default_nettype none

// compares the current source registers against the busy vector
// stack operations also wait on esp
module hazard_check (
    input  wire scoreboard_pkg::reg_mask_t busy_vec,
    input  wire x86_decode_pkg::reg_idx_t [scoreboard_pkg::NUM_SOURCES-1:0] src_reg,
    input  wire logic [scoreboard_pkg::NUM_SOURCES-1:0] src_valid,
    input  wire logic                      stack_op,
    output logic                           stall
);

    // per-slot hit, a valid slot naming a busy register
    logic [scoreboard_pkg::NUM_SOURCES-1:0] src_hit;

    logic source_stall;
    logic stack_stall;

    always_comb begin
        for (int i = 0; i < scoreboard_pkg::NUM_SOURCES; i++) begin
            src_hit[i] = src_valid[i] && busy_vec[src_reg[i]];
        end
    end

    assign source_stall = |src_hit;

    // push, pop, call and ret all touch esp implicitly
    assign stack_stall = stack_op && busy_vec[scoreboard_pkg::STACK_REG];

    // independent of in_valid, the handshake masks it when nothing is offered
    assign stall = source_stall || stack_stall;

endmodule

`default_nettype wire

// File: source/register_access_stall.sv
`default_nettype none

// register hazard scoreboard for the decode stage
// op0 writes count up, writebacks count down
// the stage stalls while a source register still has writes in flight
module register_access_stall #(
    parameter int COUNT_WIDTH = scoreboard_pkg::DEFAULT_COUNT_WIDTH
) (
    input  wire logic                      clk,
    input  wire logic                      reset,
    // upstream instruction
    input  wire logic                      in_valid,
    input  wire x86_decode_pkg::op_type_t  op0_type,
    input  wire x86_decode_pkg::reg_idx_t  op0_reg,
    input  wire x86_decode_pkg::op_type_t  op1_type,
    input  wire x86_decode_pkg::reg_idx_t  op1_reg,
    input  wire logic [7:0]                mod_rm,
    input  wire logic [7:0]                sib,
    input  wire x86_decode_pkg::reg_size_t register_size,
    input  wire logic                      stack_op,
    // downstream
    input  wire logic                      next_stage_ready,
    // writeback
    input  wire logic                      wb_valid,
    input  wire x86_decode_pkg::reg_idx_t  wb_reg,
    input  wire x86_decode_pkg::reg_size_t wb_size,
    output logic                           in_ready,
    output logic                           stall
);

    // slots 0 and 1 from op0, slots 2 and 3 from op1
    wire x86_decode_pkg::reg_idx_t [scoreboard_pkg::NUM_SOURCES-1:0] src_reg;
    wire logic [scoreboard_pkg::NUM_SOURCES-1:0] src_valid;

    wire scoreboard_pkg::reg_mask_t inc_mask;
    wire scoreboard_pkg::reg_mask_t dec_mask;
    wire scoreboard_pkg::reg_mask_t busy_vec;

    // op0 is read as well as written, e.g. add r/m, reg
    operand_source_decode op0_src_i (
        .op_type       (op0_type),
        .op_reg        (op0_reg),
        .mod_rm        (mod_rm),
        .sib           (sib),
        .register_size (register_size),
        .src0_reg      (src_reg[0]),
        .src0_valid    (src_valid[0]),
        .src1_reg      (src_reg[1]),
        .src1_valid    (src_valid[1])
    );

    operand_source_decode op1_src_i (
        .op_type       (op1_type),
        .op_reg        (op1_reg),
        .mod_rm        (mod_rm),
        .sib           (sib),
        .register_size (register_size),
        .src0_reg      (src_reg[2]),
        .src0_valid    (src_valid[2]),
        .src1_reg      (src_reg[3]),
        .src1_valid    (src_valid[3])
    );

    scoreboard_update scoreboard_update_i (
        .in_valid         (in_valid),
        .next_stage_ready (next_stage_ready),
        .stall            (stall),
        .op0_type         (op0_type),
        .op0_reg          (op0_reg),
        .mod_rm           (mod_rm),
        .register_size    (register_size),
        .wb_valid         (wb_valid),
        .wb_reg           (wb_reg),
        .wb_size          (wb_size),
        .in_ready         (in_ready),
        .inc_mask         (inc_mask),
        .dec_mask         (dec_mask)
    );

    // one counter per general register
    for (genvar r = 0; r < scoreboard_pkg::NUM_REGS; r++) begin : g_counter
        reg_busy_counter #(
            .COUNT_WIDTH (COUNT_WIDTH)
        ) counter_i (
            .clk   (clk),
            .reset (reset),
            .inc   (inc_mask[r]),
            .dec   (dec_mask[r]),
            .busy  (busy_vec[r])
        );
    end

    hazard_check hazard_check_i (
        .busy_vec  (busy_vec),
        .src_reg   (src_reg),
        .src_valid (src_valid),
        .stack_op  (stack_op),
        .stall     (stall)
    );

endmodule

`default_nettype wire

// File: testbench/register_access_stall_tb.sv
`default_nettype none

// table-driven testbench for the register hazard scoreboard
// one table row per clock cycle is driven on the falling edge
// stall and in_ready are checked a quarter period later
// rows with in_valid low only probe stall
// an offered instruction stays on the inputs until it is accepted
module register_access_stall_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int MARGIN       = 10;
    localparam int MAX_ROWS     = 40;

    // operand types and sizes used in the table
    localparam logic [2:0] T_NONE  = x86_decode_pkg::OP_NONE;
    localparam logic [2:0] T_REG   = x86_decode_pkg::OP_REGISTER;
    localparam logic [2:0] T_MODRM = x86_decode_pkg::OP_MODRM;
    localparam logic [2:0] T_IMM   = x86_decode_pkg::OP_IMMEDIATE;
    localparam logic [1:0] BYTE    = x86_decode_pkg::SIZE_BYTE;
    localparam logic [1:0] DW      = 2'd2;

    // general registers in encoding order
    localparam logic [2:0] EAX = 3'd0;
    localparam logic [2:0] ECX = 3'd1;
    localparam logic [2:0] EDX = 3'd2;
    localparam logic [2:0] EBX = 3'd3;
    localparam logic [2:0] ESP = 3'd4;
    localparam logic [2:0] EBP = 3'd5;
    localparam logic [2:0] ESI = 3'd6;
    localparam logic [2:0] EDI = 3'd7;
    // byte register bh shares the encoding of edi
    localparam logic [2:0] BH  = 3'd7;

    typedef struct packed {
        logic       in_valid;
        logic       next_stage_ready;
        logic       stack_op;
        logic [2:0] op0_type;
        logic [2:0] op0_reg;
        logic [2:0] op1_type;
        logic [2:0] op1_reg;
        logic [7:0] mod_rm;
        logic [7:0] sib;
        logic [1:0] register_size;
        logic       wb_valid;
        logic [2:0] wb_reg;
        logic [1:0] wb_size;
        logic       exp_stall;
        logic       exp_in_ready;
    } row_t;

    logic       clk;
    logic       reset;
    logic       in_valid;
    logic [2:0] op0_type;
    logic [2:0] op0_reg;
    logic [2:0] op1_type;
    logic [2:0] op1_reg;
    logic [7:0] mod_rm;
    logic [7:0] sib;
    logic [1:0] register_size;
    logic       stack_op;
    logic       next_stage_ready;
    logic       wb_valid;
    logic [2:0] wb_reg;
    logic [1:0] wb_size;
    logic       in_ready;
    logic       stall;

    row_t  rows [MAX_ROWS];
    string row_name [MAX_ROWS];
    int    num_rows;
    int    stall_errors;
    int    ready_errors;
    int    seed;
    logic  table_ready;

    register_access_stall dut_i (
        .clk              (clk),
        .reset            (reset),
        .in_valid         (in_valid),
        .op0_type         (op0_type),
        .op0_reg          (op0_reg),
        .op1_type         (op1_type),
        .op1_reg          (op1_reg),
        .mod_rm           (mod_rm),
        .sib              (sib),
        .register_size    (register_size),
        .stack_op         (stack_op),
        .next_stage_ready (next_stage_ready),
        .wb_valid         (wb_valid),
        .wb_reg           (wb_reg),
        .wb_size          (wb_size),
        .in_ready         (in_ready),
        .stall            (stall)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic add_row(
        input string      name,
        input logic       iv, nsr, stk,
        input logic [2:0] t0, r0, t1, r1,
        input logic [7:0] mrm, sb,
        input logic [1:0] sz,
        input logic       wv,
        input logic [2:0] wr,
        input logic [1:0] ws,
        input logic       e_stall, e_ready
    );
        row_name[num_rows] = name;
        // concatenation follows the struct field order
        rows[num_rows] = {iv, nsr, stk, t0, r0, t1, r1, mrm, sb, sz,
                          wv, wr, ws, e_stall, e_ready};
        num_rows++;
    endtask

    // only register and memory operands carry their register in op_reg
    function automatic logic reads_op_reg(input logic [2:0] t);
        return (t == T_REG) || (t == x86_decode_pkg::OP_MEMORY);
    endfunction

    task automatic drive_row(input int i);
        row_t        r;
        logic [31:0] noise;
        logic        modrm_used;
        logic        sib_used;
        r          = rows[i];
        noise      = $random(seed);
        modrm_used = (r.op0_type == T_MODRM) || (r.op1_type == T_MODRM);
        sib_used   = modrm_used && (r.mod_rm[7:6] != 2'b11) && (r.mod_rm[2:0] == 3'b100);
        in_valid         = r.in_valid;
        next_stage_ready = r.next_stage_ready;
        stack_op         = r.stack_op;
        op0_type         = r.op0_type;
        op1_type         = r.op1_type;
        register_size    = r.register_size;
        wb_valid         = r.wb_valid;
        // fields the row leaves unused get random values
        op0_reg = reads_op_reg(r.op0_type) ? r.op0_reg : noise[2:0];
        op1_reg = reads_op_reg(r.op1_type) ? r.op1_reg : noise[5:3];
        mod_rm  = modrm_used ? r.mod_rm : noise[13:6];
        sib     = sib_used ? r.sib : noise[21:14];
        wb_reg  = r.wb_valid ? r.wb_reg : noise[24:22];
        wb_size = r.wb_valid ? r.wb_size : noise[26:25];
    endtask

    task automatic check_row(input int i);
        assert (stall === rows[i].exp_stall) else begin
            $display("Error: %s stall expected %0b actual %0b",
                     row_name[i], rows[i].exp_stall, stall);
            stall_errors++;
        end
        assert (in_ready === rows[i].exp_in_ready) else begin
            $display("Error: %s in_ready expected %0b actual %0b",
                     row_name[i], rows[i].exp_in_ready, in_ready);
            ready_errors++;
        end
    endtask

    // each row gives name, in_valid, next_stage_ready, stack_op, op0 type and reg,
    // op1 type and reg, mod_rm, sib, size, wb_valid, wb_reg, wb_size,
    // then the expected stall and in_ready
    task automatic build_table();
        // eax write goes through on an empty scoreboard
        add_row("reset_reg_to_reg",   1, 1, 0, T_REG, EAX, T_REG, ECX,
                8'h00, 8'h00, DW, 0, EAX, DW, 0, 1);
        // read after write on ebx while eax retires
        add_row("write_ebx",          1, 1, 0, T_REG, EBX, T_IMM, EAX,
                8'h00, 8'h00, DW, 1, EAX, DW, 0, 1);
        add_row("read_ecx_only",      1, 1, 0, T_NONE, EAX, T_REG, ECX,
                8'h00, 8'h00, DW, 0, EAX, DW, 0, 1);
        add_row("raw_ebx_stalls",     1, 1, 0, T_NONE, EAX, T_REG, EBX,
                8'h00, 8'h00, DW, 0, EAX, DW, 1, 0);
        // still stalled here since the writeback lands at the end of this cycle
        add_row("raw_ebx_writeback",  1, 1, 0, T_NONE, EAX, T_REG, EBX,
                8'h00, 8'h00, DW, 1, EBX, DW, 1, 0);
        add_row("raw_ebx_cleared",    1, 1, 0, T_NONE, EAX, T_REG, EBX,
                8'h00, 8'h00, DW, 0, EAX, DW, 0, 1);
        // esi, edi, esp and ebp busy for the address forms
        add_row("write_esi",          1, 1, 0, T_REG, ESI, T_IMM, EAX,
                8'h00, 8'h00, DW, 0, EAX, DW, 0, 1);
        add_row("write_edi",          1, 1, 0, T_REG, EDI, T_IMM, EAX,
                8'h00, 8'h00, DW, 0, EAX, DW, 0, 1);
        add_row("write_esp",          1, 1, 0, T_REG, ESP, T_IMM, EAX,
                8'h00, 8'h00, DW, 0, EAX, DW, 0, 1);
        add_row("write_ebp",          1, 1, 0, T_REG, EBP, T_IMM, EAX,
                8'h00, 8'h00, DW, 0, EAX, DW, 0, 1);
        // esi as sib base with no index
        add_row("sib_base_stalls",    0, 1, 0, T_NONE, EAX, T_MODRM, EAX,
                8'h04, 8'h26, DW, 0, EAX, DW, 1, 0);
        // [eax + edi*1] through op0
        add_row("sib_index_stalls",   0, 1, 0, T_MODRM, EAX, T_NONE, EAX,
                8'h04, 8'h38, DW, 0, EAX, DW, 1, 0);
        // index field 100 must not look at the busy esp
        add_row("sib_no_index",       1, 1, 0, T_NONE, EAX, T_MODRM, EAX,
                8'h04, 8'h21, DW, 0, EAX, DW, 0, 1);
        add_row("modrm_disp8_ebp",    0, 1, 0, T_NONE, EAX, T_MODRM, EAX,
                8'h45, 8'h00, DW, 0, EAX, DW, 1, 0);
        add_row("modrm_disp32",       1, 1, 0, T_NONE, EAX, T_MODRM, EAX,
                8'h05, 8'h00, DW, 0, EAX, DW, 0, 1);
        // stack operation against esp
        add_row("esp_busy_no_stack",  1, 1, 0, T_NONE, EAX, T_NONE, EAX,
                8'h00, 8'h00, DW, 1, ESI, DW, 0, 1);
        add_row("stack_esp_busy",     1, 1, 1, T_NONE, EAX, T_NONE, EAX,
                8'h00, 8'h00, DW, 1, ESP, DW, 1, 0);
        add_row("stack_esp_idle",     1, 1, 1, T_NONE, EAX, T_NONE, EAX,
                8'h00, 8'h00, DW, 0, EAX, DW, 0, 1);
        // bh write marks ebx while edi and ebp retire
        add_row("byte_write_bh",      1, 1, 0, T_REG, BH, T_IMM, EAX,
                8'h00, 8'h00, BYTE, 1, EDI, DW, 0, 1);
        add_row("bh_marks_ebx",       0, 1, 0, T_NONE, EAX, T_REG, EBX,
                8'h00, 8'h00, DW, 1, EBP, DW, 1, 0);
        add_row("bh_leaves_edi",      1, 1, 0, T_NONE, EAX, T_REG, EDI,
                8'h00, 8'h00, DW, 0, EAX, DW, 0, 1);
        add_row("byte_writeback_bh",  0, 1, 0, T_NONE, EAX, T_NONE, EAX,
                8'h00, 8'h00, DW, 1, BH, BYTE, 0, 1);
        add_row("ebx_after_byte_wb",  1, 1, 0, T_NONE, EAX, T_REG, EBX,
                8'h00, 8'h00, DW, 0, EAX, DW, 0, 1);
        // nothing is accepted while downstream is not ready
        add_row("bp_write_eax",       1, 0, 0, T_REG, EAX, T_IMM, EAX,
                8'h00, 8'h00, DW, 0, EAX, DW, 0, 0);
        // the held write reads eax and would stall had it been marked
        add_row("bp_eax_not_marked",  1, 1, 0, T_REG, EAX, T_IMM, EAX,
                8'h00, 8'h00, DW, 0, EAX, DW, 0, 1);
        add_row("write_ecx",          1, 1, 0, T_REG, ECX, T_IMM, EAX,
                8'h00, 8'h00, DW, 0, EAX, DW, 0, 1);
        // writeback still retires while held
        add_row("bp_writeback_ecx",   1, 0, 0, T_NONE, EAX, T_REG, ECX,
                8'h00, 8'h00, DW, 1, ECX, DW, 1, 0);
        add_row("ecx_free_after_bp",  1, 1, 0, T_NONE, EAX, T_REG, ECX,
                8'h00, 8'h00, DW, 0, EAX, DW, 0, 1);
        // issue and retire of edx in one cycle leave its count at zero
        add_row("accept_with_wb_edx", 1, 1, 0, T_REG, EDX, T_IMM, EAX,
                8'h00, 8'h00, DW, 1, EDX, DW, 0, 1);
        add_row("edx_count_held",     1, 1, 0, T_NONE, EAX, T_REG, EDX,
                8'h00, 8'h00, DW, 0, EAX, DW, 0, 1);
    endtask

    initial begin
        seed             = 9877;
        num_rows         = 0;
        stall_errors     = 0;
        ready_errors     = 0;
        table_ready      = 1'b0;
        reset            = 1'b1;
        in_valid         = 1'b0;
        op0_type         = T_NONE;
        op0_reg          = EAX;
        op1_type         = T_NONE;
        op1_reg          = EAX;
        mod_rm           = 8'h00;
        sib              = 8'h00;
        register_size    = DW;
        stack_op         = 1'b0;
        next_stage_ready = 1'b1;
        wb_valid         = 1'b0;
        wb_reg           = EAX;
        wb_size          = DW;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < num_rows; i++) begin
            drive_row(i);
            #(CLK_PERIOD / 4);
            check_row(i);
            @(negedge clk);
        end
        $display("stall errors: %0d, in_ready errors: %0d", stall_errors, ready_errors);
        if (stall_errors + ready_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // run length follows the table size
    initial begin
        wait (table_ready === 1'b1);
        #((num_rows + RESET_CYCLES + MARGIN) * CLK_PERIOD);
        $display("Watchdog expired before all table rows were applied");
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
source/x86_decode_pkg.sv
source/scoreboard_pkg.sv
source/operand_source_decode.sv
source/scoreboard_update.sv
source/reg_busy_counter.sv
source/hazard_check.sv
source/register_access_stall.sv
testbench/register_access_stall_tb.sv
